/* lc4_alu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_alu_pipe (
   input  logic                       gwe,
   input  logic                       rst_n,
   input  logic                       issue_valid,
   input  logic [lc4_pkg::ROB_W-1:0]  issue_index,
   input  logic [lc4_pkg::XLEN-1:0]   issue_insn,
   input  logic [lc4_pkg::PREG_W-1:0] issue_pd,
   input  logic [lc4_pkg::XLEN-1:0]   rs_value,
   input  logic [lc4_pkg::XLEN-1:0]   rt_value,
   output logic                       wb_valid,
   output logic [lc4_pkg::ROB_W-1:0]  wb_index,
   output logic [lc4_pkg::PREG_W-1:0] wb_preg,
   output logic [lc4_pkg::XLEN-1:0]   wb_value
);

   logic                       s1_valid;
   logic [lc4_pkg::ROB_W-1:0]  s1_index;
   logic [lc4_pkg::XLEN-1:0]   s1_insn, s1_rs, s1_rt;
   logic [lc4_pkg::PREG_W-1:0] s1_pd;
   logic [lc4_pkg::XLEN-1:0]   imm5, imm9, result;

   assign imm5 = {{11{s1_insn[4]}}, s1_insn[4:0]};
   assign imm9 = {{7{s1_insn[8]}}, s1_insn[8:0]};

   always_comb begin
      result = '0;                          // Anything outside the subset
      case (s1_insn[15:12])
         lc4_pkg::OP_ARITH:
            if (s1_insn[5])
               result = s1_rs + imm5;
            else
               case (s1_insn[4:3])
                  2'b00:   result = s1_rs + s1_rt;
                  2'b01:   result = s1_rs * s1_rt;
                  2'b10:   result = s1_rs - s1_rt;
                  default: result = '0;     // DIV
               endcase
         lc4_pkg::OP_LOGIC:
            if (s1_insn[5])
               result = s1_rs & imm5;
            else
               case (s1_insn[4:3])
                  2'b00:   result = s1_rs & s1_rt;
                  2'b01:   result = ~s1_rs;
                  2'b10:   result = s1_rs | s1_rt;
                  default: result = s1_rs ^ s1_rt;
               endcase
         lc4_pkg::OP_CONST: result = imm9;
         default:           result = '0;
      endcase
   end

   always_ff @(posedge gwe or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         s1_valid <= issue_valid;
         wb_valid <= s1_valid && lc4_pkg::insn_writes_rd(s1_insn);  // No-ops drop out here
      end
   end

   // Operand latch, then result register
   always_ff @(posedge gwe) begin
      s1_index <= issue_index;
      s1_insn  <= issue_insn;
      s1_pd    <= issue_pd;
      s1_rs    <= rs_value;
      s1_rt    <= rt_value;
      wb_index <= s1_index;
      wb_preg  <= s1_pd;
      wb_value <= result;
   end

endmodule

`default_nettype wire

/* lc4_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch (
   input  logic                     gwe,
   input  logic                     rst_n,
   output logic [lc4_pkg::XLEN-1:0] imem_addr,
   input  logic [lc4_pkg::XLEN-1:0] imem_out,
   input  logic                     credit_return,
   output logic                     fetch_valid,
   output logic [lc4_pkg::XLEN-1:0] fetch_pc,
   output logic [lc4_pkg::XLEN-1:0] fetch_insn
);

   logic [lc4_pkg::XLEN-1:0]     pc_q;
   logic [lc4_pkg::CREDIT_W-1:0] credits_q;  // Free reorder-buffer slots

   assign fetch_valid = (credits_q != '0);
   assign imem_addr   = pc_q;
   assign fetch_pc    = pc_q;
   assign fetch_insn  = imem_out;            // Memory answers in the same cycle

   always_ff @(posedge gwe or negedge rst_n) begin
      if (!rst_n) begin
         pc_q      <= lc4_pkg::RESET_PC;
         credits_q <= lc4_pkg::ROB_DEPTH[lc4_pkg::CREDIT_W-1:0];
      end else begin
         if (fetch_valid)
            pc_q <= pc_q + 1'b1;             // PC holds while out of credits
         // Take and return in the same cycle cancel out
         case ({fetch_valid, credit_return})
            2'b10:   credits_q <= credits_q - 1'b1;
            2'b01:   credits_q <= credits_q + 1'b1;
            default: credits_q <= credits_q;
         endcase
      end
   end

endmodule

`default_nettype wire

/* lc4_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_ooo_core (
   input  logic                       gwe,
   input  logic                       rst_n,
   output logic [lc4_pkg::XLEN-1:0]   imem_addr,
   input  logic [lc4_pkg::XLEN-1:0]   imem_out,
   output logic                       commit_valid,
   output logic [lc4_pkg::XLEN-1:0]   commit_pc,
   output logic [lc4_pkg::XLEN-1:0]   commit_insn,
   output logic [lc4_pkg::XLEN-1:0]   commit_value,
   output logic                       commit_we,
   output logic [lc4_pkg::AREG_W-1:0] commit_reg,
   output logic [2:0]                 commit_nzp
);

   logic                       fetch_valid, credit_return, alloc_valid;
   logic [lc4_pkg::XLEN-1:0]   fetch_pc, fetch_insn;
   logic [lc4_pkg::PREG_W-1:0] ps1, ps2, pd, pd_old;
   logic                       free_valid;
   logic [lc4_pkg::PREG_W-1:0] free_preg;
   logic [lc4_pkg::PREG_W-1:0] rd1_preg, rd2_preg;
   logic [lc4_pkg::XLEN-1:0]   rd1_value, rd2_value;
   logic [lc4_pkg::PREG_N-1:0] ready;
   logic                       issue_valid;
   logic [lc4_pkg::ROB_W-1:0]  issue_index;
   logic [lc4_pkg::XLEN-1:0]   issue_insn;
   logic [lc4_pkg::PREG_W-1:0] issue_pd;
   logic                       wb_valid;
   logic [lc4_pkg::ROB_W-1:0]  wb_index;
   logic [lc4_pkg::PREG_W-1:0] wb_preg;
   logic [lc4_pkg::XLEN-1:0]   wb_value;

   // Fresh destination loses its ready bit
   assign alloc_valid = fetch_valid && lc4_pkg::insn_writes_rd(fetch_insn);

   lc4_fetch i_fetch (.gwe, .rst_n, .imem_addr, .imem_out, .credit_return,
                      .fetch_valid, .fetch_pc, .fetch_insn);

   lc4_rename i_rename (.gwe, .rst_n, .fetch_valid, .fetch_insn, .ps1, .ps2, .pd, .pd_old,
                        .free_valid, .free_preg);

   lc4_prf i_prf (.gwe, .rst_n, .alloc_valid, .alloc_preg(pd), .rd1_preg, .rd2_preg,
                  .rd1_value, .rd2_value, .ready, .wb_valid, .wb_preg, .wb_value);

   lc4_rob i_rob (.gwe, .rst_n, .fetch_valid, .fetch_pc, .fetch_insn, .ps1, .ps2, .pd, .pd_old,
                  .ready, .rd1_preg, .rd2_preg, .issue_valid, .issue_index, .issue_insn,
                  .issue_pd, .wb_valid, .wb_index, .wb_value, .credit_return, .free_valid,
                  .free_preg, .commit_valid, .commit_pc, .commit_insn, .commit_value,
                  .commit_we, .commit_reg, .commit_nzp);

   lc4_alu_pipe i_alu (.gwe, .rst_n, .issue_valid, .issue_index, .issue_insn, .issue_pd,
                       .rs_value(rd1_value), .rt_value(rd2_value),
                       .wb_valid, .wb_index, .wb_preg, .wb_value);

endmodule

`default_nettype wire

/* lc4_pkg.sv */
`default_nettype none

package lc4_pkg;

   localparam int XLEN      = 16;
   localparam int AREG_W    = 3;   // 8 architectural registers
   localparam int PREG_N    = 16;
   localparam int PREG_W    = 4;
   localparam int FREE_N    = 8;   // Physical registers not mapped at reset
   localparam int FREE_W    = 3;
   localparam int ROB_DEPTH = 4;
   localparam int ROB_W     = 2;
   localparam int CREDIT_W  = 3;

   localparam logic [XLEN-1:0] RESET_PC = 16'h8200;

   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_CONST = 4'b1001;

   // ADD, MUL, SUB and the immediate ADD write; DIV is outside the subset
   function automatic logic insn_writes_rd(input logic [XLEN-1:0] insn);
      case (insn[15:12])
         OP_ARITH: return insn[5] || (insn[4:3] != 2'b11);
         OP_LOGIC: return 1'b1;
         OP_CONST: return 1'b1;
         default:  return 1'b0;
      endcase
   endfunction

   function automatic logic insn_reads_rs(input logic [XLEN-1:0] insn);
      case (insn[15:12])
         OP_ARITH: return insn[5] || (insn[4:3] != 2'b11);
         OP_LOGIC: return 1'b1;
         default:  return 1'b0;
      endcase
   endfunction

   // Immediate forms and NOT have no second source
   function automatic logic insn_reads_rt(input logic [XLEN-1:0] insn);
      case (insn[15:12])
         OP_ARITH: return !insn[5] && (insn[4:3] != 2'b11);
         OP_LOGIC: return !insn[5] && (insn[4:3] != 2'b01);
         default:  return 1'b0;
      endcase
   endfunction

   function automatic logic [2:0] nzp_of(input logic [XLEN-1:0] value);
      if (value == '0)
         return 3'b010;
      else if (value[XLEN-1])
         return 3'b100;
      else
         return 3'b001;
   endfunction

endpackage

`default_nettype wire

/* lc4_prf.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_prf (
   input  logic                       gwe,
   input  logic                       rst_n,
   input  logic                       alloc_valid,
   input  logic [lc4_pkg::PREG_W-1:0] alloc_preg,
   input  logic [lc4_pkg::PREG_W-1:0] rd1_preg,
   input  logic [lc4_pkg::PREG_W-1:0] rd2_preg,
   output logic [lc4_pkg::XLEN-1:0]   rd1_value,
   output logic [lc4_pkg::XLEN-1:0]   rd2_value,
   output logic [lc4_pkg::PREG_N-1:0] ready,
   input  logic                       wb_valid,
   input  logic [lc4_pkg::PREG_W-1:0] wb_preg,
   input  logic [lc4_pkg::XLEN-1:0]   wb_value
);

   logic [lc4_pkg::XLEN-1:0]   regs_q [lc4_pkg::PREG_N];
   logic [lc4_pkg::PREG_N-1:0] ready_q;
   logic [lc4_pkg::PREG_N-1:0] wb_hit;

   always_comb begin
      wb_hit          = '0;
      wb_hit[wb_preg] = wb_valid;
   end

   // A writeback makes its register usable in the same cycle
   assign ready     = ready_q | wb_hit;
   assign rd1_value = (wb_valid && wb_preg == rd1_preg) ? wb_value : regs_q[rd1_preg];
   assign rd2_value = (wb_valid && wb_preg == rd2_preg) ? wb_value : regs_q[rd2_preg];

   always_ff @(posedge gwe or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < lc4_pkg::PREG_N; i++)
            regs_q[i] <= '0;
         ready_q <= '1;
      end else begin
         if (alloc_valid)
            ready_q[alloc_preg] <= 1'b0;   // Value pending until writeback
         if (wb_valid) begin
            regs_q[wb_preg]  <= wb_value;
            ready_q[wb_preg] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* lc4_rename.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_rename (
   input  logic                       gwe,
   input  logic                       rst_n,
   input  logic                       fetch_valid,
   input  logic [lc4_pkg::XLEN-1:0]   fetch_insn,
   output logic [lc4_pkg::PREG_W-1:0] ps1,
   output logic [lc4_pkg::PREG_W-1:0] ps2,
   output logic [lc4_pkg::PREG_W-1:0] pd,
   output logic [lc4_pkg::PREG_W-1:0] pd_old,
   input  logic                       free_valid,
   input  logic [lc4_pkg::PREG_W-1:0] free_preg
);

   localparam int AREG_N = 1 << lc4_pkg::AREG_W;

   logic [lc4_pkg::PREG_W-1:0] map_q  [AREG_N];
   logic [lc4_pkg::PREG_W-1:0] free_q [lc4_pkg::FREE_N];
   logic [lc4_pkg::FREE_W-1:0] fl_head_q;   // Next register to hand out
   logic [lc4_pkg::FREE_W-1:0] fl_tail_q;   // Slot for the next recycled register
   logic [lc4_pkg::AREG_W-1:0] rd, rs, rt;
   logic                       alloc;

   // Register fields of the LC4 word
   assign rd = fetch_insn[11:9];
   assign rs = fetch_insn[8:6];
   assign rt = fetch_insn[2:0];

   assign alloc  = fetch_valid && lc4_pkg::insn_writes_rd(fetch_insn);
   assign ps1    = map_q[rs];
   assign ps2    = map_q[rt];
   assign pd_old = map_q[rd];
   assign pd     = alloc ? free_q[fl_head_q] : map_q[rd];

   // Free list cannot run dry with at most ROB_DEPTH allocations in flight
   always_ff @(posedge gwe or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < AREG_N; i++)
            map_q[i] <= i[lc4_pkg::PREG_W-1:0];
         for (int i = 0; i < lc4_pkg::FREE_N; i++)
            free_q[i] <= i[lc4_pkg::PREG_W-1:0] + AREG_N[lc4_pkg::PREG_W-1:0];
         fl_head_q <= '0;
         fl_tail_q <= '0;
      end else begin
         if (alloc) begin
            map_q[rd] <= free_q[fl_head_q];
            fl_head_q <= fl_head_q + 1'b1;
         end
         if (free_valid) begin                // Old mapping of a committed write
            free_q[fl_tail_q] <= free_preg;
            fl_tail_q         <= fl_tail_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* lc4_rob.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_rob (
   input  logic                       gwe,
   input  logic                       rst_n,
   input  logic                       fetch_valid,
   input  logic [lc4_pkg::XLEN-1:0]   fetch_pc,
   input  logic [lc4_pkg::XLEN-1:0]   fetch_insn,
   input  logic [lc4_pkg::PREG_W-1:0] ps1,
   input  logic [lc4_pkg::PREG_W-1:0] ps2,
   input  logic [lc4_pkg::PREG_W-1:0] pd,
   input  logic [lc4_pkg::PREG_W-1:0] pd_old,
   input  logic [lc4_pkg::PREG_N-1:0] ready,
   output logic [lc4_pkg::PREG_W-1:0] rd1_preg,
   output logic [lc4_pkg::PREG_W-1:0] rd2_preg,
   output logic                       issue_valid,
   output logic [lc4_pkg::ROB_W-1:0]  issue_index,
   output logic [lc4_pkg::XLEN-1:0]   issue_insn,
   output logic [lc4_pkg::PREG_W-1:0] issue_pd,
   input  logic                       wb_valid,
   input  logic [lc4_pkg::ROB_W-1:0]  wb_index,
   input  logic [lc4_pkg::XLEN-1:0]   wb_value,
   output logic                       credit_return,
   output logic                       free_valid,
   output logic [lc4_pkg::PREG_W-1:0] free_preg,
   output logic                       commit_valid,
   output logic [lc4_pkg::XLEN-1:0]   commit_pc,
   output logic [lc4_pkg::XLEN-1:0]   commit_insn,
   output logic [lc4_pkg::XLEN-1:0]   commit_value,
   output logic                       commit_we,
   output logic [lc4_pkg::AREG_W-1:0] commit_reg,
   output logic [2:0]                 commit_nzp
);

   logic [lc4_pkg::XLEN-1:0]   pc_q     [lc4_pkg::ROB_DEPTH];
   logic [lc4_pkg::XLEN-1:0]   insn_q   [lc4_pkg::ROB_DEPTH];
   logic [lc4_pkg::XLEN-1:0]   result_q [lc4_pkg::ROB_DEPTH];
   logic [lc4_pkg::PREG_W-1:0] ps1_q    [lc4_pkg::ROB_DEPTH];
   logic [lc4_pkg::PREG_W-1:0] ps2_q    [lc4_pkg::ROB_DEPTH];
   logic [lc4_pkg::PREG_W-1:0] pd_q     [lc4_pkg::ROB_DEPTH];
   logic [lc4_pkg::PREG_W-1:0] pd_old_q [lc4_pkg::ROB_DEPTH];

   logic [lc4_pkg::ROB_DEPTH-1:0] entry_valid;
   logic [lc4_pkg::ROB_DEPTH-1:0] issued;
   logic [lc4_pkg::ROB_DEPTH-1:0] done;
   logic [lc4_pkg::ROB_W-1:0]     head_q, tail_q;
   logic                          issue_nop;

   // Oldest ready entry, scanning from the head
   always_comb begin
      logic [lc4_pkg::ROB_W-1:0] idx;
      logic                      srcs_ok;
      issue_valid = 1'b0;
      issue_index = head_q;
      for (int i = 0; i < lc4_pkg::ROB_DEPTH; i++) begin
         idx     = head_q + i[lc4_pkg::ROB_W-1:0];
         srcs_ok = (!lc4_pkg::insn_reads_rs(insn_q[idx]) || ready[ps1_q[idx]]) &&
                   (!lc4_pkg::insn_reads_rt(insn_q[idx]) || ready[ps2_q[idx]]);
         if (!issue_valid && entry_valid[idx] && !issued[idx] && srcs_ok) begin
            issue_valid = 1'b1;
            issue_index = idx;
         end
      end
   end

   assign rd1_preg   = ps1_q[issue_index];
   assign rd2_preg   = ps2_q[issue_index];
   assign issue_insn = insn_q[issue_index];
   assign issue_pd   = pd_q[issue_index];
   assign issue_nop  = issue_valid && !lc4_pkg::insn_writes_rd(issue_insn);  // No writeback

   assign commit_valid  = entry_valid[head_q] && done[head_q];
   assign commit_pc     = pc_q[head_q];
   assign commit_insn   = insn_q[head_q];
   assign commit_value  = result_q[head_q];
   assign commit_we     = lc4_pkg::insn_writes_rd(commit_insn);
   assign commit_reg    = commit_insn[11:9];
   assign commit_nzp    = lc4_pkg::nzp_of(commit_value);
   assign credit_return = commit_valid;
   assign free_valid    = commit_valid && commit_we;
   assign free_preg     = pd_old_q[head_q];

   always_ff @(posedge gwe or negedge rst_n) begin
      if (!rst_n) begin
         entry_valid <= '0;
         issued      <= '0;
         done        <= '0;
         head_q      <= '0;
         tail_q      <= '0;
      end else begin
         if (commit_valid) begin
            entry_valid[head_q] <= 1'b0;
            head_q              <= head_q + 1'b1;
         end
         if (fetch_valid) begin             // Credit guarantees a free slot
            entry_valid[tail_q] <= 1'b1;
            issued[tail_q]      <= 1'b0;
            done[tail_q]        <= 1'b0;
            tail_q              <= tail_q + 1'b1;
         end
         if (issue_valid)
            issued[issue_index] <= 1'b1;
         if (issue_nop)
            done[issue_index] <= 1'b1;
         if (wb_valid)
            done[wb_index] <= 1'b1;
      end
   end

   always_ff @(posedge gwe) begin
      if (fetch_valid) begin
         pc_q[tail_q]     <= fetch_pc;
         insn_q[tail_q]   <= fetch_insn;
         ps1_q[tail_q]    <= ps1;
         ps2_q[tail_q]    <= ps2;
         pd_q[tail_q]     <= pd;
         pd_old_q[tail_q] <= pd_old;
      end
      if (issue_nop)
         result_q[issue_index] <= '0;
      if (wb_valid)
         result_q[wb_index] <= wb_value;
   end

endmodule

`default_nettype wire

/* lc4_rob_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_rob_checker (
   input logic                            gwe,
   input logic                            rst_n,
   input logic                            fetch_valid,
   input logic                            credit_return,
   input logic                            commit_valid,
   input logic [lc4_pkg::ROB_DEPTH-1:0]   entry_valid,
   input logic [lc4_pkg::ROB_DEPTH-1:0]   issued,
   input logic [lc4_pkg::ROB_W-1:0]       head_q,
   input logic [lc4_pkg::ROB_W-1:0]       tail_q
);

   logic [lc4_pkg::CREDIT_W-1:0] credits;     // Follows the fetch credit counter
   logic [lc4_pkg::CREDIT_W-1:0] in_flight;   // Enqueues not yet committed
   logic [lc4_pkg::CREDIT_W-1:0] occupancy;

   always_comb begin
      occupancy = '0;
      for (int i = 0; i < lc4_pkg::ROB_DEPTH; i++)
         occupancy = occupancy + entry_valid[i];
   end

   always_ff @(posedge gwe or negedge rst_n) begin
      if (!rst_n) begin
         credits   <= lc4_pkg::ROB_DEPTH[lc4_pkg::CREDIT_W-1:0];
         in_flight <= '0;
      end else begin
         credits   <= credits - fetch_valid + credit_return;
         in_flight <= in_flight + fetch_valid - commit_valid;
      end
   end

   a_occupancy_max: assert property (@(posedge gwe) disable iff (!rst_n)
      in_flight <= lc4_pkg::ROB_DEPTH)
      else $error("Reorder buffer holds %0d entries", in_flight);

   a_credit_balance: assert property (@(posedge gwe) disable iff (!rst_n)
      credits + occupancy == lc4_pkg::ROB_DEPTH)
      else $error("Credits %0d and occupancy %0d out of balance", credits, occupancy);

   // A committing head entry went through issue
   a_commit_head: assert property (@(posedge gwe) disable iff (!rst_n)
      commit_valid |-> issued[head_q])
      else $error("Commit of a head entry that never issued");

   // Enqueue must land in a free slot
   a_enqueue_free: assert property (@(posedge gwe) disable iff (!rst_n)
      fetch_valid |-> !entry_valid[tail_q])
      else $error("Enqueue into an occupied entry");

endmodule

bind lc4_rob lc4_rob_checker i_rob_checker (
   .gwe(gwe),
   .rst_n(rst_n),
   .fetch_valid(fetch_valid),
   .credit_return(credit_return),
   .commit_valid(commit_valid),
   .entry_valid(entry_valid),
   .issued(issued),
   .head_q(head_q),
   .tail_q(tail_q)
);

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module tb_lc4_ooo_core -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vtb_lc4_ooo_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
   exit 0
fi
exit 1

/* sim.f */
lc4_pkg.sv
lc4_fetch.sv
lc4_rename.sv
lc4_prf.sv
lc4_rob.sv
lc4_alu_pipe.sv
lc4_ooo_core.sv
tb_clock_gen.sv
lc4_rob_checker.sv
tb_lc4_ooo_core.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic gwe,
   output logic por_n
);

   initial begin
      gwe = 1'b0;
      forever #20 gwe = ~gwe;     // 40 ns period
   end

   // Power-on reset held for the first 10 cycles
   initial begin
      por_n = 1'b0;
      repeat (10) @(posedge gwe);
      por_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* tb_lc4_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_ooo_core;

   localparam logic [31:0] LFSR_SEED = 32'h2500f311;
   localparam logic [15:0] PC_START  = 16'h8200;
   localparam logic [3:0]  OPC_ARITH = 4'h1;
   localparam logic [3:0]  OPC_LOGIC = 4'h5;
   localparam logic [3:0]  OPC_CONST = 4'h9;
   // Sub-opcodes in bits 5:3, bit 5 clear for the register forms
   localparam logic [2:0]  F_ADD = 3'd0, F_MUL = 3'd1, F_SUB = 3'd2, F_DIV = 3'd3;
   localparam logic [2:0]  F_AND = 3'd0, F_NOT = 3'd1, F_OR = 3'd2, F_XOR = 3'd3;

   logic        gwe, por_n, test_rst_n, rst_n;
   logic [15:0] imem_addr, imem_out;
   logic        commit_valid, commit_we;
   logic [15:0] commit_pc, commit_insn, commit_value;
   logic [2:0]  commit_reg, commit_nzp;

   logic [15:0] imem [64];
   int          prog_len;
   logic [15:0] prog [$];
   logic [15:0] ref_regs [8];       // Architectural state of the reference model
   logic        exp_we [64];
   logic [15:0] exp_val [64];
   logic [31:0] lfsr;
   int          errors;

   tb_clock_gen i_clk (.gwe, .por_n);

   assign rst_n = por_n & test_rst_n;

   lc4_ooo_core i_dut (.gwe, .rst_n, .imem_addr, .imem_out, .commit_valid, .commit_pc,
                       .commit_insn, .commit_value, .commit_we, .commit_reg, .commit_nzp);

   // Combinational instruction memory, zero past the program
   always_comb begin
      logic [15:0] offset;
      offset = imem_addr - PC_START;
      if (offset < prog_len)
         imem_out = imem[offset[5:0]];
      else
         imem_out = '0;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[14:0], lfsr[0]};
      end
   endtask

   function automatic logic [15:0] enc_rr(input logic [3:0] op, input logic [2:0] f,
                                          input logic [2:0] d, s, t);
      return {op, d, s, f, t};
   endfunction

   function automatic logic [15:0] enc_ri(input logic [3:0] op, input logic [2:0] d, s,
                                          input logic [4:0] imm);
      return {op, d, s, 1'b1, imm};
   endfunction

   function automatic logic [15:0] enc_const(input logic [2:0] d, input logic [8:0] imm);
      return {OPC_CONST, d, imm};
   endfunction

   function automatic logic [2:0] nzp_expect(input logic [15:0] v);
      return v[15] ? 3'b100 : ((v == 16'h0000) ? 3'b010 : 3'b001);
   endfunction

   // In-order execution of one instruction on the architectural registers
   task automatic ref_exec(input logic [15:0] insn, output logic we, output logic [15:0] val);
      logic [15:0] a, b, imm5;
      a    = ref_regs[insn[8:6]];
      b    = ref_regs[insn[2:0]];
      imm5 = {{11{insn[4]}}, insn[4:0]};
      we   = 1'b1;
      val  = '0;
      case (insn[15:12])
         OPC_ARITH: case (insn[5:3])
            F_ADD:   val = a + b;
            F_MUL:   val = a * b;
            F_SUB:   val = a - b;
            F_DIV:   we = 1'b0;          // Outside the subset
            default: val = a + imm5;
         endcase
         OPC_LOGIC: case (insn[5:3])
            F_AND:   val = a & b;
            F_NOT:   val = ~a;
            F_OR:    val = a | b;
            F_XOR:   val = a ^ b;
            default: val = a & imm5;
         endcase
         OPC_CONST: val = {{7{insn[8]}}, insn[8:0]};
         default:   we = 1'b0;
      endcase
      if (we)
         ref_regs[insn[11:9]] = val;
   endtask

   task automatic compare_field(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic push_rand_const(input logic [2:0] d);
      logic [15:0] r;
      rand_bits(9, r);
      prog.push_back(enc_const(d, r[8:0]));
   endtask

   // Reset the core, load the program and check every commit in order
   task automatic run_program(input string name);
      int          n, cyc, idx, fetched;
      logic [15:0] last_addr;
      string       ctx;
      $display("Running %s test", name);
      @(posedge gwe);
      test_rst_n <= 1'b0;
      @(negedge gwe);
      n = prog.size();
      for (int r = 0; r < 8; r++)
         ref_regs[r] = '0;
      for (int i = 0; i < n; i++) begin
         imem[i] = prog[i];
         ref_exec(prog[i], exp_we[i], exp_val[i]);
      end
      prog_len = n;
      cyc = 0;
      while ((cyc < 2 || !por_n) && cyc < 20) begin
         compare_field("commit_valid in reset", {15'd0, commit_valid}, 16'h0000);
         compare_field("fetch address in reset", imem_addr, PC_START);
         @(negedge gwe);
         cyc++;
      end
      if (!por_n) begin
         errors++;
         $display("Power-on reset was never released");
      end
      @(posedge gwe);
      test_rst_n <= 1'b1;
      cyc       = 0;
      idx       = 0;
      fetched   = 0;
      last_addr = PC_START;
      while (idx < n && cyc < 12 * n + 20) begin
         @(negedge gwe);
         if (cyc == 0)
            compare_field("first fetch address", imem_addr, PC_START);
         if (cyc < 4)                     // Earliest commit is the fifth cycle
            compare_field("early commit_valid", {15'd0, commit_valid}, 16'h0000);
         if (imem_addr !== last_addr) begin
            compare_field("next fetch address", imem_addr, last_addr + 16'd1);
            fetched++;                    // Address left behind was enqueued
            last_addr = imem_addr;
         end
         assert (fetched - idx <= lc4_pkg::ROB_DEPTH) else begin
            errors++;
            $display("[ERROR] %0t: %0d fetched but only %0d committed", $time, fetched, idx);
         end
         if (commit_valid) begin
            ctx = $sformatf("%s commit %0d", name, idx);
            compare_field({ctx, " pc"}, commit_pc, PC_START + idx[15:0]);
            compare_field({ctx, " insn"}, commit_insn, prog[idx]);
            compare_field({ctx, " we"}, {15'd0, commit_we}, {15'd0, exp_we[idx]});
            if (exp_we[idx]) begin
               compare_field({ctx, " reg"}, {13'd0, commit_reg}, {13'd0, prog[idx][11:9]});
               compare_field({ctx, " value"}, commit_value, exp_val[idx]);
               compare_field({ctx, " nzp"}, {13'd0, commit_nzp},
                             {13'd0, nzp_expect(exp_val[idx])});
            end
            idx++;
         end
         cyc++;
      end
      if (idx < n) begin
         errors++;
         $display("Timeout in %s test: %0d of %0d instructions committed", name, idx, n);
      end
      prog.delete();
   endtask

   task automatic test_independent();
      logic [15:0] r;
      push_rand_const(3'd1);
      push_rand_const(3'd2);
      push_rand_const(3'd3);
      push_rand_const(3'd4);
      prog.push_back(enc_rr(OPC_ARITH, F_ADD, 3'd5, 3'd1, 3'd2));
      prog.push_back(enc_rr(OPC_ARITH, F_SUB, 3'd6, 3'd3, 3'd4));
      prog.push_back(enc_rr(OPC_ARITH, F_MUL, 3'd7, 3'd1, 3'd4));
      rand_bits(5, r);
      prog.push_back(enc_ri(OPC_ARITH, 3'd0, 3'd2, r[4:0]));
      run_program("independent");
   endtask

   // Each link reads the one before, with a younger CONST free to issue early
   task automatic test_chain();
      push_rand_const(3'd1);
      prog.push_back(enc_rr(OPC_ARITH, F_ADD, 3'd2, 3'd1, 3'd1));
      push_rand_const(3'd7);
      prog.push_back(enc_rr(OPC_ARITH, F_MUL, 3'd3, 3'd2, 3'd1));
      prog.push_back(enc_rr(OPC_ARITH, F_SUB, 3'd4, 3'd3, 3'd7));
      prog.push_back(enc_ri(OPC_ARITH, 3'd5, 3'd4, 5'b11101));
      prog.push_back(enc_rr(OPC_LOGIC, F_XOR, 3'd6, 3'd5, 3'd2));
      prog.push_back(enc_rr(OPC_ARITH, F_MUL, 3'd1, 3'd6, 3'd6));
      prog.push_back(enc_rr(OPC_ARITH, F_ADD, 3'd2, 3'd1, 3'd5));
      prog.push_back(enc_rr(OPC_ARITH, F_SUB, 3'd3, 3'd2, 3'd6));
      run_program("chain");
   endtask

   task automatic test_recycle();
      logic [15:0] r;
      push_rand_const(3'd1);
      push_rand_const(3'd2);
      for (int i = 0; i < 20; i++) begin
         rand_bits(5, r);
         if (i % 2 == 0)
            prog.push_back(enc_ri(OPC_ARITH, 3'd1, 3'd2, r[4:0]));
         else
            prog.push_back(enc_rr(OPC_ARITH, F_SUB, 3'd2, 3'd1, 3'd2));
         if (i % 4 == 3)                  // Reader of both hot registers
            prog.push_back(enc_rr(OPC_LOGIC, F_OR, 3'd3, 3'd1, 3'd2));
      end
      run_program("recycle");
   endtask

   task automatic test_logic();
      logic [15:0] r;
      for (int k = 0; k < 2; k++) begin
         push_rand_const(3'd1);
         push_rand_const(3'd2);
         push_rand_const(3'd3);
         prog.push_back(enc_const(3'd0, 9'd0));
         prog.push_back(enc_rr(OPC_LOGIC, F_AND, 3'd4, 3'd1, 3'd2));
         prog.push_back(enc_rr(OPC_LOGIC, F_NOT, 3'd5, 3'd1, 3'd0));
         prog.push_back(enc_rr(OPC_LOGIC, F_OR, 3'd6, 3'd2, 3'd3));
         prog.push_back(enc_rr(OPC_LOGIC, F_XOR, 3'd7, 3'd3, 3'd1));
         rand_bits(10, r);
         prog.push_back(enc_ri(OPC_LOGIC, 3'd0, 3'd2, r[4:0]));
         prog.push_back(enc_ri(OPC_ARITH, 3'd4, 3'd3, r[9:5]));
         prog.push_back(16'h0000);                                  // Branch that never branches
         prog.push_back(enc_rr(OPC_ARITH, F_DIV, 3'd1, 3'd2, 3'd3));
         prog.push_back(16'h6A85);                                  // LDR
         prog.push_back(16'hA3C2);                                  // Shift
         prog.push_back(16'hD1FF);                                  // HICONST
      end
      run_program("logic");
   endtask

   initial begin
      test_rst_n = 1'b1;
      prog_len   = 0;
      errors     = 0;
      lfsr       = LFSR_SEED;
      test_independent();
      test_chain();
      test_recycle();
      test_logic();
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
